//--- scoreboard.f
common/sb_cfg_pkg.sv
common/sb_types_pkg.sv
common/sb_wb_if.sv
src/prio_select.sv
scoreboard/sb_entry_store.sv
scoreboard/sb_clobber_map.sv
scoreboard/sb_operand_fwd.sv
scoreboard/scoreboard_top.sv
test/sb_checker.sv
test/tb_scoreboard.sv

//--- Makefile
TOP = tb_scoreboard

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f scoreboard.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_scoreboard.sv
// random issue, write-back and commit traffic against a cycle model of the scoreboard
// register addresses are kept to x0..x7 so clobber and bypass hits are frequent
`timescale 1ns/1ns
`default_nettype none

module tb_scoreboard;
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  localparam int NumTests = 3;
  localparam int TotalCycles = 300 + 16 + 200;

  logic clk_i;
  logic rst_ni;
  sb_entry_t decoded_instr;
  logic decoded_valid;
  logic issue_ack;
  logic unresolved_branch;
  logic flush_unissued;
  logic flush;
  logic [NrCommitPorts-1:0] commit_ack;
  logic [NrWbPorts-1:0] wb_valid;
  logic [NrWbPorts-1:0][EntryIdxBits-1:0] wb_trans_id;
  logic [NrWbPorts-1:0][XLen-1:0] wb_data;
  logic [NrWbPorts-1:0] wb_ex;
  logic [RegAddrBits-1:0] rs1;
  logic [RegAddrBits-1:0] rs2;

  logic decoded_ack;
  sb_entry_t issue_instr;
  logic issue_valid;
  logic sb_full;
  sb_entry_t [NrCommitPorts-1:0] commit_instr;
  logic [XLen-1:0] rs1_data;
  logic [XLen-1:0] rs2_data;
  logic rs1_valid;
  logic rs2_valid;
  fu_e [NrRegs-1:0] clobber;

  // model state
  sb_slot_t m_slot [NrEntries];
  logic [EntryIdxBits-1:0] m_iptr;
  logic [EntryIdxBits-1:0] m_cptr;
  logic [EntryIdxBits-1:0] m_cnt;

  // expected outputs for the cycle that is being driven
  logic exp_dack;
  logic exp_iv;
  logic exp_full;
  sb_entry_t exp_issue;
  sb_entry_t [NrCommitPorts-1:0] exp_commit;
  fu_e [NrRegs-1:0] exp_clobber;
  logic [32:0] exp_rs1;
  logic [32:0] exp_rs2;

  logic chk_en;
  int test_id;
  int err_cnt;
  int chk_cnt;
  logic [31:0] lfsr;

  scoreboard_top uut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .decoded_instr_i     (decoded_instr),
    .decoded_valid_i     (decoded_valid),
    .decoded_ack_o       (decoded_ack),
    .issue_instr_o       (issue_instr),
    .issue_valid_o       (issue_valid),
    .issue_ack_i         (issue_ack),
    .unresolved_branch_i (unresolved_branch),
    .flush_unissued_i    (flush_unissued),
    .flush_i             (flush),
    .sb_full_o           (sb_full),
    .commit_instr_o      (commit_instr),
    .commit_ack_i        (commit_ack),
    .wb_valid_i          (wb_valid),
    .wb_trans_id_i       (wb_trans_id),
    .wb_data_i           (wb_data),
    .wb_ex_i             (wb_ex),
    .rs1_i               (rs1),
    .rs2_i               (rs2),
    .rs1_o               (rs1_data),
    .rs2_o               (rs2_data),
    .rs1_valid_o         (rs1_valid),
    .rs2_valid_o         (rs2_valid),
    .clobber_o           (clobber)
  );

  sb_checker u_chk (
    .clk_i          (clk_i),
    .en_i           (chk_en),
    .test_id_i      (test_id),
    .act_dack_i     (decoded_ack),
    .exp_dack_i     (exp_dack),
    .act_iv_i       (issue_valid),
    .exp_iv_i       (exp_iv),
    .act_full_i     (sb_full),
    .exp_full_i     (exp_full),
    .act_issue_i    (issue_instr),
    .exp_issue_i    (exp_issue),
    .act_commit_i   (commit_instr),
    .exp_commit_i   (exp_commit),
    .act_clobber_i  (clobber),
    .exp_clobber_i  (exp_clobber),
    .act_rs1_i      ({rs1_valid, rs1_data}),
    .exp_rs1_i      (exp_rs1),
    .act_rs2_i      ({rs2_valid, rs2_data}),
    .exp_rs2_i      (exp_rs2),
    .err_cnt_o      (err_cnt),
    .chk_cnt_o      (chk_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // random source and reference model
  // ----------------------------------------------------------------------
  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // one clock edge of the scoreboard, using the inputs driven in the last cycle
  function automatic void sb_model();
    sb_slot_t nxt [NrEntries];
    logic en;
    logic [EntryIdxBits-1:0] idx;
    logic [EntryIdxBits-1:0] ncom;
    nxt = m_slot;
    en  = decoded_valid && issue_ack && (m_cnt != 3'd7) && !flush_unissued;
    if (en) begin
      nxt[m_iptr].issued       = 1'b1;
      nxt[m_iptr].sbe          = decoded_instr;
      nxt[m_iptr].sbe.trans_id = m_iptr;
    end
    // entries without a unit finish by themselves
    for (int i = 0; i < NrEntries; i++) begin
      if (m_slot[i].issued && m_slot[i].sbe.fu == NONE) begin
        nxt[i].sbe.valid = 1'b1;
      end
    end
    for (int p = 0; p < NrWbPorts; p++) begin
      if (wb_valid[p] && m_slot[wb_trans_id[p]].issued) begin
        nxt[wb_trans_id[p]].sbe.valid    = 1'b1;
        nxt[wb_trans_id[p]].sbe.result   = wb_data[p];
        nxt[wb_trans_id[p]].sbe.ex_valid = nxt[wb_trans_id[p]].sbe.ex_valid | wb_ex[p];
      end
    end
    ncom = '0;
    for (int k = 0; k < NrCommitPorts; k++) begin
      if (commit_ack[k]) begin
        idx                  = m_cptr + 3'(k);
        nxt[idx].issued      = 1'b0;
        nxt[idx].sbe.valid   = 1'b0;
        ncom                 = ncom + 3'd1;
      end
    end
    if (flush) begin
      for (int i = 0; i < NrEntries; i++) begin
        nxt[i].issued       = 1'b0;
        nxt[i].sbe.valid    = 1'b0;
        nxt[i].sbe.ex_valid = 1'b0;
      end
      m_iptr = '0;
      m_cptr = '0;
      m_cnt  = '0;
    end else begin
      m_iptr = m_iptr + 3'(en);
      m_cptr = m_cptr + ncom;
      m_cnt  = m_cnt - ncom + 3'(en);
    end
    m_slot = nxt;
  endfunction

  // bypass rule: write-back ports first, then finished slots, lowest index wins
  function automatic logic [32:0] fwd_lookup(input logic [4:0] rs,
                                             input logic [1:0] wbv,
                                             input logic [1:0] wbe,
                                             input logic [1:0][2:0] wbt,
                                             input logic [1:0][31:0] wbd);
    logic [32:0] hit;
    hit = '0;
    for (int i = int'(NrEntries) - 1; i >= 0; i--) begin
      if (m_slot[i].issued && m_slot[i].sbe.valid && m_slot[i].sbe.rd == rs) begin
        hit = {1'b1, m_slot[i].sbe.result};
      end
    end
    for (int p = int'(NrWbPorts) - 1; p >= 0; p--) begin
      if (wbv[p] && !wbe[p] && m_slot[wbt[p]].sbe.rd == rs) begin
        hit = {1'b1, wbd[p]};
      end
    end
    if (rs == 5'd0) begin
      hit[32] = 1'b0;
    end
    return hit;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus, mode 0 mixed traffic, 1 fill without commit, 2 frequent flush
  // ----------------------------------------------------------------------
  task automatic step(input int mode);
    sb_entry_t n_instr;
    logic n_dv;
    logic n_br;
    logic n_iv;
    logic n_iack;
    logic n_fu;
    logic n_fl;
    logic [1:0] n_cack;
    logic [1:0] n_wbv;
    logic [1:0] n_wbe;
    logic [1:0][2:0] n_wbt;
    logic [1:0][31:0] n_wbd;
    logic [4:0] n_rs1;
    logic [4:0] n_rs2;
    sb_model();
    test_id = mode;
    n_instr        = '0;
    n_instr.fu     = fu_e'(3'(rand_bits(3) % 32'd6));
    n_instr.rd     = 5'(rand_bits(3));
    n_instr.result = rand_bits(32);
    n_dv   = (mode == 1) ? 1'b1 : (rand_bits(2) != 32'd0);
    n_br   = (mode == 1) ? 1'b0 : (rand_bits(3) == 32'd0);
    n_iv   = n_dv && !n_br && (m_cnt != 3'd7);
    n_iack = n_iv && ((mode == 1) || rand_bits(1) != 32'd0);
    n_fu   = (mode != 1) && (rand_bits(4) == 32'd0);
    n_fl   = (mode == 2) ? (rand_bits(3) == 32'd0) : (mode == 0 && rand_bits(6) == 32'd0);
    // ack only what is valid, port 1 only along with port 0
    n_cack = '0;
    if (mode != 1) begin
      n_cack[0] = m_slot[m_cptr].sbe.valid && rand_bits(1) != 32'd0;
      n_cack[1] = n_cack[0] && m_slot[m_cptr + 3'd1].sbe.valid && rand_bits(1) != 32'd0;
    end
    n_wbv[0] = rand_bits(1) != 32'd0;
    n_wbv[1] = rand_bits(1) != 32'd0;
    n_wbe[0] = rand_bits(2) == 32'd0;
    n_wbe[1] = rand_bits(2) == 32'd0;
    n_wbt[0] = 3'(rand_bits(3));
    n_wbt[1] = n_wbt[0] + 3'(32'd1 + rand_bits(3) % 32'd7);
    n_wbd[0] = rand_bits(32);
    n_wbd[1] = rand_bits(32);
    n_rs1 = 5'(rand_bits(3));
    n_rs2 = 5'(rand_bits(3));

    exp_iv   = n_iv;
    exp_full = (m_cnt == 3'd7);
    exp_dack = n_iack && !exp_full;
    // decoded instruction passes through with the next slot as its ID
    exp_issue          = n_instr;
    exp_issue.trans_id = m_iptr;
    for (int k = 0; k < NrCommitPorts; k++) begin
      exp_commit[k]          = m_slot[m_cptr + 3'(k)].sbe;
      exp_commit[k].trans_id = m_cptr + 3'(k);
    end
    for (int r = 0; r < NrRegs; r++) begin
      exp_clobber[r] = NONE;
      for (int i = int'(NrEntries) - 1; i >= 0; i--) begin
        if (r != 0 && m_slot[i].issued && m_slot[i].sbe.rd == 5'(r)) begin
          exp_clobber[r] = m_slot[i].sbe.fu;
        end
      end
    end
    exp_rs1 = fwd_lookup(n_rs1, n_wbv, n_wbe, n_wbt, n_wbd);
    exp_rs2 = fwd_lookup(n_rs2, n_wbv, n_wbe, n_wbt, n_wbd);
    chk_en = 1'b1;

    decoded_instr     <= n_instr;
    decoded_valid     <= n_dv;
    unresolved_branch <= n_br;
    issue_ack         <= n_iack;
    flush_unissued    <= n_fu;
    flush             <= n_fl;
    commit_ack        <= n_cack;
    wb_valid          <= n_wbv;
    wb_ex             <= n_wbe;
    wb_trans_id       <= n_wbt;
    wb_data           <= n_wbd;
    rs1               <= n_rs1;
    rs2               <= n_rs2;
  endtask

  function automatic int test_len(input int t);
    case (t)
      0: return 300;
      1: return 16;
      default: return 200;
    endcase
  endfunction

  initial begin
    lfsr              = 32'h7a20_7d28;
    rst_ni            = 1'b0;
    decoded_instr     = '0;
    decoded_valid     = 1'b0;
    issue_ack         = 1'b0;
    unresolved_branch = 1'b0;
    flush_unissued    = 1'b0;
    flush             = 1'b0;
    commit_ack        = '0;
    wb_valid          = '0;
    wb_trans_id       = '0;
    wb_data           = '0;
    wb_ex             = '0;
    rs1               = '0;
    rs2               = '0;
    m_slot            = '{default: '0};
    m_iptr            = '0;
    m_cptr            = '0;
    m_cnt             = '0;
    chk_en            = 1'b0;
    test_id           = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int t = 0; t < NumTests; t++) begin
      repeat (test_len(t)) begin
        @(posedge clk_i);
        step(t);
      end
    end
    // drain, the checker closes the last test when the id goes away
    @(posedge clk_i);
    chk_en = 1'b0;
    test_id = -1;
    decoded_valid <= 1'b0;
    issue_ack     <= 1'b0;
    commit_ack    <= '0;
    wb_valid      <= '0;
    flush         <= 1'b0;
    repeat (2) @(posedge clk_i);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((TotalCycles + 50) * 10);
    $display("timeout, the tests did not reach their end");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/sb_checker.sv
// compares DUT outputs with the model on the falling edge, inputs settle on the rising one
// commit and operand data are only checked where the expected valid is high
`timescale 1ns/1ns
`default_nettype none

module sb_checker (
  input  logic                                                    clk_i,
  input  logic                                                    en_i,
  input  int                                                      test_id_i,
  input  logic                                                    act_dack_i,
  input  logic                                                    exp_dack_i,
  input  logic                                                    act_iv_i,
  input  logic                                                    exp_iv_i,
  input  logic                                                    act_full_i,
  input  logic                                                    exp_full_i,
  input  sb_types_pkg::sb_entry_t                                 act_issue_i,
  input  sb_types_pkg::sb_entry_t                                 exp_issue_i,
  input  sb_types_pkg::sb_entry_t [sb_cfg_pkg::NrCommitPorts-1:0] act_commit_i,
  input  sb_types_pkg::sb_entry_t [sb_cfg_pkg::NrCommitPorts-1:0] exp_commit_i,
  input  sb_types_pkg::fu_e [sb_cfg_pkg::NrRegs-1:0]              act_clobber_i,
  input  sb_types_pkg::fu_e [sb_cfg_pkg::NrRegs-1:0]              exp_clobber_i,
  input  logic [32:0]                                             act_rs1_i,
  input  logic [32:0]                                             exp_rs1_i,
  input  logic [32:0]                                             act_rs2_i,
  input  logic [32:0]                                             exp_rs2_i,
  output int                                                      err_cnt_o,
  output int                                                      chk_cnt_o
);
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  int last_id = -1;
  int test_err = 0;
  int test_chk = 0;

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

  task automatic compare_bits(input logic [63:0] act, input logic [63:0] exp,
                              input string what);
    chk_cnt_o++;
    test_chk++;
    if (act !== exp) begin
      err_cnt_o++;
      test_err++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, act, exp);
    end
  endtask

  always @(negedge clk_i) begin
    // close the previous test once the id moves on
    if (test_id_i != last_id) begin
      if (last_id >= 0) begin
        $display("test %0d done, %0d checks, %0d errors", last_id, test_chk, test_err);
      end
      last_id  = test_id_i;
      test_chk = 0;
      test_err = 0;
    end
    if (en_i) begin
      compare_bits(64'(act_dack_i), 64'(exp_dack_i), "decoded_ack_o");
      compare_bits(64'(act_iv_i), 64'(exp_iv_i), "issue_valid_o");
      compare_bits(64'(act_full_i), 64'(exp_full_i), "sb_full_o");
      compare_bits(64'(act_issue_i), 64'(exp_issue_i), "issue_instr_o");
      for (int k = 0; k < NrCommitPorts; k++) begin
        compare_bits(64'(act_commit_i[k].valid), 64'(exp_commit_i[k].valid),
                     $sformatf("commit %0d valid", k));
        compare_bits(64'(act_commit_i[k].trans_id), 64'(exp_commit_i[k].trans_id),
                     $sformatf("commit %0d trans_id", k));
        // stale fields of free slots carry no meaning
        if (exp_commit_i[k].valid) begin
          compare_bits(64'(act_commit_i[k]), 64'(exp_commit_i[k]),
                       $sformatf("commit %0d entry", k));
        end
      end
      for (int r = 0; r < NrRegs; r++) begin
        compare_bits(64'(act_clobber_i[r]), 64'(exp_clobber_i[r]),
                     $sformatf("clobber_o[%0d]", r));
      end
      compare_bits(64'(act_rs1_i[32]), 64'(exp_rs1_i[32]), "rs1_valid_o");
      compare_bits(64'(act_rs2_i[32]), 64'(exp_rs2_i[32]), "rs2_valid_o");
      if (exp_rs1_i[32]) begin
        compare_bits(64'(act_rs1_i[31:0]), 64'(exp_rs1_i[31:0]), "rs1_o");
      end
      if (exp_rs2_i[32]) begin
        compare_bits(64'(act_rs2_i[31:0]), 64'(exp_rs2_i[31:0]), "rs2_o");
      end
    end
  end

endmodule

`default_nettype wire

//--- scoreboard/scoreboard_top.sv
// eight-slot scoreboard with 2 write-back and 2 commit ports
// commit ports follow the valid/ack rules of the entry store
`timescale 1ns/1ns
`default_nettype none

module scoreboard_top (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  sb_types_pkg::sb_entry_t                                 decoded_instr_i,
  input  logic                                                    decoded_valid_i,
  output logic                                                    decoded_ack_o,
  output sb_types_pkg::sb_entry_t                                 issue_instr_o,
  output logic                                                    issue_valid_o,
  input  logic                                                    issue_ack_i,
  input  logic                                                    unresolved_branch_i,
  input  logic                                                    flush_unissued_i,
  input  logic                                                    flush_i,
  output logic                                                    sb_full_o,
  output sb_types_pkg::sb_entry_t [sb_cfg_pkg::NrCommitPorts-1:0] commit_instr_o,
  input  logic [sb_cfg_pkg::NrCommitPorts-1:0]                    commit_ack_i,
  input  logic [sb_cfg_pkg::NrWbPorts-1:0]                        wb_valid_i,
  input  logic [sb_cfg_pkg::NrWbPorts-1:0][sb_cfg_pkg::EntryIdxBits-1:0] wb_trans_id_i,
  input  logic [sb_cfg_pkg::NrWbPorts-1:0][sb_cfg_pkg::XLen-1:0]  wb_data_i,
  input  logic [sb_cfg_pkg::NrWbPorts-1:0]                        wb_ex_i,
  input  logic [sb_cfg_pkg::RegAddrBits-1:0]                      rs1_i,
  input  logic [sb_cfg_pkg::RegAddrBits-1:0]                      rs2_i,
  output logic [sb_cfg_pkg::XLen-1:0]                             rs1_o,
  output logic [sb_cfg_pkg::XLen-1:0]                             rs2_o,
  output logic                                                    rs1_valid_o,
  output logic                                                    rs2_valid_o,
  output sb_types_pkg::fu_e [sb_cfg_pkg::NrRegs-1:0]              clobber_o
);
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  sb_slot_t slots [NrEntries];
  sb_wb_if  wb_bus [NrWbPorts] ();

  // bundle the flat write-back ports
  for (genvar p = 0; p < NrWbPorts; p++) begin : gen_wb
    assign wb_bus[p].wb_valid = wb_valid_i[p];
    assign wb_bus[p].trans_id = wb_trans_id_i[p];
    assign wb_bus[p].data     = wb_data_i[p];
    assign wb_bus[p].ex_valid = wb_ex_i[p];
  end

  sb_entry_store i_store (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .decoded_instr_i     (decoded_instr_i),
    .decoded_valid_i     (decoded_valid_i),
    .issue_ack_i         (issue_ack_i),
    .unresolved_branch_i (unresolved_branch_i),
    .flush_unissued_i    (flush_unissued_i),
    .flush_i             (flush_i),
    .wb_if               (wb_bus),
    .commit_ack_i        (commit_ack_i),
    .commit_instr_o      (commit_instr_o),
    .issue_instr_o       (issue_instr_o),
    .issue_valid_o       (issue_valid_o),
    .decoded_ack_o       (decoded_ack_o),
    .sb_full_o           (sb_full_o),
    .slots_o             (slots)
  );

  sb_clobber_map i_clobber (
    .slots_i   (slots),
    .clobber_o (clobber_o)
  );

  sb_operand_fwd i_fwd (
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .slots_i     (slots),
    .wb_if       (wb_bus),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

`default_nettype wire

//--- scoreboard/sb_operand_fwd.sv
// combinational bypass for rs1/rs2; write-back ports win over finished slots
// results carrying an exception on a write-back port are never forwarded
`timescale 1ns/1ns
`default_nettype none

module sb_operand_fwd (
  input  logic [sb_cfg_pkg::RegAddrBits-1:0] rs1_i,
  input  logic [sb_cfg_pkg::RegAddrBits-1:0] rs2_i,
  input  sb_types_pkg::sb_slot_t             slots_i [sb_cfg_pkg::NrEntries],
  sb_wb_if.fwd                               wb_if [sb_cfg_pkg::NrWbPorts],
  output logic [sb_cfg_pkg::XLen-1:0]        rs1_o,
  output logic [sb_cfg_pkg::XLen-1:0]        rs2_o,
  output logic                               rs1_valid_o,
  output logic                               rs2_valid_o
);
  import sb_cfg_pkg::*;

  // write-back ports first, then slots, in priority order
  localparam int unsigned NumSrc = NrWbPorts + NrEntries;

  logic [XLen-1:0]        src_data [NumSrc];
  logic [RegAddrBits-1:0] src_rd [NumSrc];
  // candidate holds a usable result
  logic [NumSrc-1:0]      src_ok;
  logic [RegAddrBits-1:0] rs_addr [2];
  logic [XLen-1:0]        rs_data [2];
  logic [1:0]             rs_found;

  for (genvar p = 0; p < NrWbPorts; p++) begin : gen_wb_src
    assign src_data[p] = wb_if[p].data;
    assign src_rd[p]   = slots_i[wb_if[p].trans_id].sbe.rd;
    assign src_ok[p]   = wb_if[p].wb_valid & ~wb_if[p].ex_valid;
  end

  for (genvar i = 0; i < NrEntries; i++) begin : gen_slot_src
    assign src_data[NrWbPorts+i] = slots_i[i].sbe.result;
    assign src_rd[NrWbPorts+i]   = slots_i[i].sbe.rd;
    assign src_ok[NrWbPorts+i]   = slots_i[i].issued & slots_i[i].sbe.valid;
  end

  assign rs_addr[0] = rs1_i;
  assign rs_addr[1] = rs2_i;

  // one selector per source operand
  for (genvar s = 0; s < 2; s++) begin : gen_operand
    logic [NumSrc-1:0] req;

    always_comb begin
      for (int c = 0; c < NumSrc; c++) begin
        req[c] = src_ok[c] && (src_rd[c] == rs_addr[s]);
      end
    end

    prio_select #(
      .NumIn     (NumSrc),
      .payload_t (logic [XLen-1:0])
    ) i_sel (
      .req_i   (req),
      .data_i  (src_data),
      .data_o  (rs_data[s]),
      .valid_o (rs_found[s])
    );
  end

  // x0 reads as the register file, never bypassed
  assign rs1_o       = rs_data[0];
  assign rs2_o       = rs_data[1];
  assign rs1_valid_o = rs_found[0] & (|rs1_i);
  assign rs2_valid_o = rs_found[1] & (|rs2_i);

endmodule

`default_nettype wire

//--- scoreboard/sb_clobber_map.sv
// purely combinational; x0 never reports a pending writer
`timescale 1ns/1ns
`default_nettype none

module sb_clobber_map (
  input  sb_types_pkg::sb_slot_t                     slots_i [sb_cfg_pkg::NrEntries],
  output sb_types_pkg::fu_e [sb_cfg_pkg::NrRegs-1:0] clobber_o
);
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  // last input is the NONE default, picked when no slot claims the register
  fu_e clobber_fu [NrEntries+1];

  always_comb begin
    for (int i = 0; i < NrEntries; i++) begin
      clobber_fu[i] = slots_i[i].sbe.fu;
    end
    clobber_fu[NrEntries] = NONE;
  end

  for (genvar r = 0; r < NrRegs; r++) begin : gen_reg
    logic [NrEntries:0] req;

    // issued slots targeting this register, none for x0
    always_comb begin
      req = '0;
      for (int i = 0; i < NrEntries; i++) begin
        req[i] = slots_i[i].issued && (slots_i[i].sbe.rd == RegAddrBits'(r)) && (r != 0);
      end
    end

    prio_select #(
      .NumIn     (NrEntries + 1),
      .payload_t (fu_e)
    ) i_sel (
      .req_i   (req),
      .data_i  (clobber_fu),
      .data_o  (clobber_o[r]),
      .valid_o ()
    );
  end

  always_comb begin
    assert (clobber_o[0] == NONE) else $error("x0 reported as clobbered");
  end

endmodule

`default_nettype wire

//--- scoreboard/sb_entry_store.sv
// at most NrEntries-1 instructions in flight; commit_ack_i[1] only with commit_ack_i[0]
// write-backs to slots that are not issued are dropped
`timescale 1ns/1ns
`default_nettype none

module sb_entry_store (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  sb_types_pkg::sb_entry_t                                 decoded_instr_i,
  input  logic                                                    decoded_valid_i,
  input  logic                                                    issue_ack_i,
  input  logic                                                    unresolved_branch_i,
  input  logic                                                    flush_unissued_i,
  input  logic                                                    flush_i,
  sb_wb_if.store                                                  wb_if [sb_cfg_pkg::NrWbPorts],
  input  logic [sb_cfg_pkg::NrCommitPorts-1:0]                    commit_ack_i,
  output sb_types_pkg::sb_entry_t [sb_cfg_pkg::NrCommitPorts-1:0] commit_instr_o,
  output sb_types_pkg::sb_entry_t                                 issue_instr_o,
  output logic                                                    issue_valid_o,
  output logic                                                    decoded_ack_o,
  output logic                                                    sb_full_o,
  output sb_types_pkg::sb_slot_t                                  slots_o [sb_cfg_pkg::NrEntries]
);
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  sb_slot_t                mem_q [NrEntries];
  sb_slot_t                mem_n [NrEntries];
  logic [EntryIdxBits-1:0] issue_ptr_q;
  logic [EntryIdxBits-1:0] commit_ptr_q;
  logic [EntryIdxBits-1:0] cnt_q;
  logic [EntryIdxBits-1:0] num_commit;
  logic [EntryIdxBits-1:0] commit_idx [NrCommitPorts];
  logic                    issue_en;

  // local copies of the write-back bundles, indexable in loops
  logic [NrWbPorts-1:0]    wb_valid;
  logic [NrWbPorts-1:0]    wb_ex;
  logic [EntryIdxBits-1:0] wb_tid [NrWbPorts];
  logic [XLen-1:0]         wb_data [NrWbPorts];

  for (genvar p = 0; p < NrWbPorts; p++) begin : gen_wb
    assign wb_valid[p] = wb_if[p].wb_valid;
    assign wb_ex[p]    = wb_if[p].ex_valid;
    assign wb_tid[p]   = wb_if[p].trans_id;
    assign wb_data[p]  = wb_if[p].data;
  end

  // one slot stays empty, so count never wraps
  assign sb_full_o = (cnt_q == EntryIdxBits'(NrEntries - 1));

  // issue side, trans ID is the slot we write next
  always_comb begin
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_ptr_q;
  end
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~sb_full_o;
  assign decoded_ack_o = issue_ack_i & ~sb_full_o;
  assign issue_en      = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  // commit side, oldest entries straight from the ring
  always_comb begin
    num_commit = '0;
    for (int k = 0; k < NrCommitPorts; k++) begin
      commit_idx[k]              = commit_ptr_q + EntryIdxBits'(k);
      commit_instr_o[k]          = mem_q[commit_idx[k]].sbe;
      commit_instr_o[k].trans_id = commit_idx[k];
      num_commit                 = num_commit + EntryIdxBits'(commit_ack_i[k]);
    end
  end

  // ------------------------------------------------------------------
  // slot next state
  // ------------------------------------------------------------------
  always_comb begin
    mem_n = mem_q;
    if (issue_en) begin
      mem_n[issue_ptr_q].issued = 1'b1;
      mem_n[issue_ptr_q].sbe    = issue_instr_o;
    end
    // no unit to wait for, finished one cycle after issue
    for (int i = 0; i < NrEntries; i++) begin
      if (mem_q[i].issued && mem_q[i].sbe.fu == NONE) begin
        mem_n[i].sbe.valid = 1'b1;
      end
    end
    // late results after a flush hit a free slot and are ignored
    for (int p = 0; p < NrWbPorts; p++) begin
      if (wb_valid[p] && mem_q[wb_tid[p]].issued) begin
        mem_n[wb_tid[p]].sbe.valid  = 1'b1;
        mem_n[wb_tid[p]].sbe.result = wb_data[p];
        if (wb_ex[p]) begin
          mem_n[wb_tid[p]].sbe.ex_valid = 1'b1;
        end
      end
    end
    for (int k = 0; k < NrCommitPorts; k++) begin
      if (commit_ack_i[k]) begin
        mem_n[commit_idx[k]].issued    = 1'b0;
        mem_n[commit_idx[k]].sbe.valid = 1'b0;
      end
    end
    if (flush_i) begin
      for (int i = 0; i < NrEntries; i++) begin
        mem_n[i].issued       = 1'b0;
        mem_n[i].sbe.valid    = 1'b0;
        mem_n[i].sbe.ex_valid = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q        <= '{default: '0};
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      mem_q <= mem_n;
      if (flush_i) begin
        issue_ptr_q  <= '0;
        commit_ptr_q <= '0;
        cnt_q        <= '0;
      end else begin
        issue_ptr_q  <= issue_ptr_q + EntryIdxBits'(issue_en);
        commit_ptr_q <= commit_ptr_q + num_commit;
        cnt_q        <= cnt_q - num_commit + EntryIdxBits'(issue_en);
      end
    end
  end

  assign slots_o = mem_q;

  // ------------------------------------------------------------------
  // handshake rules of the issue and commit stages
  // ------------------------------------------------------------------
  for (genvar k = 0; k < NrCommitPorts; k++) begin : gen_commit_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[k] |-> commit_instr_o[k].valid)
      else $error("commit ack on an entry that has no result");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o)
    else $error("issue ack without a valid issue instruction");

  // two units never finish the same instruction in one cycle
  for (genvar i = 0; i < NrWbPorts; i++) begin : gen_wb_chk
    for (genvar j = i + 1; j < NrWbPorts; j++) begin : gen_pair
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_valid[i] && wb_valid[j]) |-> (wb_tid[i] != wb_tid[j]))
        else $error("write-back ports carry the same trans_id");
    end
  end

endmodule

`default_nettype wire

//--- src/prio_select.sv
// fixed priority, lowest index wins
// with no request active the last input is passed through and valid_o is low
`timescale 1ns/1ns
`default_nettype none

module prio_select #(
  parameter int unsigned NumIn = 2,
  parameter type         payload_t = logic
) (
  input  logic [NumIn-1:0] req_i,
  input  payload_t         data_i [NumIn],
  output payload_t         data_o,
  output logic             valid_o
);

  // walk from the top down so the lowest requester is assigned last
  always_comb begin
    data_o = data_i[NumIn-1];
    for (int i = int'(NumIn) - 2; i >= 0; i--) begin
      if (req_i[i]) begin
        data_o = data_i[i];
      end
    end
  end

  assign valid_o = |req_i;

endmodule

`default_nettype wire

//--- common/sb_wb_if.sv
// one write-back port; data is only meaningful while wb_valid is high
`timescale 1ns/1ns
`default_nettype none

interface sb_wb_if ();
  import sb_cfg_pkg::*;

  logic                    wb_valid;
  logic [EntryIdxBits-1:0] trans_id;
  logic [XLen-1:0]         data;
  logic                    ex_valid;

  // slot update side
  modport store (input wb_valid, input trans_id, input data, input ex_valid);

  // operand bypass side
  modport fwd (input wb_valid, input trans_id, input data, input ex_valid);

endinterface

`default_nettype wire

//--- common/sb_types_pkg.sv
// record types shared by the scoreboard blocks
// the exception record is reduced to a single valid bit
`default_nettype none

package sb_types_pkg;

  // functional unit that produces the result
  typedef enum logic [2:0] {
    NONE,   // result known at decode, no unit involved
    ALU,
    LOAD,
    STORE,
    MULT,
    CSR
  } fu_e;

  // one decoded instruction as seen by issue and commit, 45 bits
  typedef struct packed {
    // result present, entry may retire
    logic                                valid;
    fu_e                                 fu;
    logic [sb_cfg_pkg::RegAddrBits-1:0]  rd;
    logic [sb_cfg_pkg::XLen-1:0]         result;
    // unit reported an exception
    logic                                ex_valid;
    // slot index, doubles as transaction ID
    logic [sb_cfg_pkg::EntryIdxBits-1:0] trans_id;
  } sb_entry_t;

  // ring slot, issued marks it as occupied
  typedef struct packed {
    logic      issued;
    sb_entry_t sbe;
  } sb_slot_t;

endpackage

`default_nettype wire

//--- common/sb_cfg_pkg.sv
// scoreboard sizes; NrEntries must be a power of two so the ring pointers wrap
// EntryIdxBits has to equal $clog2(NrEntries), it is not derived
`default_nettype none

package sb_cfg_pkg;

  // ring depth and slot index width
  localparam int unsigned NrEntries = 8;
  localparam int unsigned EntryIdxBits = 3;

  // result and retire ports
  localparam int unsigned NrWbPorts = 2;
  localparam int unsigned NrCommitPorts = 2;

  // integer register file
  localparam int unsigned RegAddrBits = 5;
  localparam int unsigned NrRegs = 32;

  // data path width
  localparam int unsigned XLen = 32;

endpackage

`default_nettype wire
